/* cdb_top.f */
logic/cdb_pkg.sv
logic/result_queue.sv
logic/cdb_arbiter.sv
logic/tag_scoreboard.sv
logic/cdb_top.sv
test/cdb_monitor.sv
test/tb_cdb_top.sv

/* Bender.yml */
package:
  name: cdb_top

sources:
  - logic/cdb_pkg.sv
  - logic/result_queue.sv
  - logic/cdb_arbiter.sv
  - logic/tag_scoreboard.sv
  - logic/cdb_top.sv
  - target: test
    files:
      - test/cdb_monitor.sv
      - test/tb_cdb_top.sv

/* test/cdb_patterns.txt */
# per unit 0..3: valid tag data wreg (data r = random), then alloc_valid alloc_tag, flush,
# then qry_tag0 exp0 qry_tag1 exp1 (exp - = not checked from this file), all fields hex
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  1 10  0  10 1 11 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  10 0 11 1
1 10 r 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  10 0 11 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  10 0 11 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  10 0 11 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  10 0 11 1
0 00 0 0  1 10 r 1  0 00 0 0  0 00 0 0  0 00  0  10 0 11 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  10 0 11 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  10 1 11 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  10 1 11 1
0 00 0 0  0 00 0 0  1 14 r 1  0 00 0 0  0 00  0  14 1 10 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  14 1 10 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  1 14  0  14 1 10 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  14 0 10 1
1 20 r 1  1 21 r 1  1 22 deadbeef 1  1 23 r 1  0 00  0  14 0 10 1
1 24 r 1  1 25 r 0  1 26 r 1  1 27 r 1  0 00  0  14 0 10 1
1 28 r 1  1 29 r 1  1 2a r 1  1 2b r 0  0 00  0  14 0 10 1
1 2c r 0  1 2d r 1  1 2e r 1  1 2f r 1  0 00  0  14 0 10 1
1 30 r 1  1 31 r 1  1 32 r 1  1 33 r 1  0 00  0  14 0 10 1
1 34 r 1  1 35 r 1  1 36 r 0  1 37 r 1  0 00  0  14 0 10 1
1 38 r 1  1 39 r 1  1 3a r 1  1 3b r 1  0 00  0  14 0 10 1
1 3c r 1  1 3d r 0  1 3e r 1  1 3f r 1  0 00  0  14 0 10 1
1 20 r 1  1 21 r 1  1 22 r 1  1 23 r 1  0 00  0  14 0 10 1
1 24 r 1  1 25 r 1  1 26 r 1  1 27 r 1  0 00  0  14 0 10 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  1  14 0 10 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  14 1 10 1
0 00 0 0  0 00 0 0  0 00 0 0  1 3a r 1  1 3a  0  3a 1 10 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  3a - 10 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  3a - 10 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  3a - 10 1
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  0 00  0  3a 1 10 1

/* test/tb_cdb_top.sv */
`default_nettype none

module tb_cdb_top import cdb_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD   = 40;
    localparam int    SEED         = 59;
    localparam int    QUEUE_DEPTH  = 4;
    localparam int    RESET_CYCLES = 4;
    localparam int    DRAIN_CYCLES = 12;
    localparam int    NUM_FIELDS   = 23;
    localparam string PATTERN_FILE = "test/cdb_patterns.txt";

    logic  clk;
    logic  arst_n;
    logic  flush;
    logic  res_valid [UNIT_COUNT];
    tag_t  res_tag   [UNIT_COUNT];
    data_t res_data  [UNIT_COUNT];
    logic  res_wreg  [UNIT_COUNT];
    logic  res_ready [UNIT_COUNT];
    logic  alloc_valid;
    tag_t  alloc_tag;
    tag_t  qry_tag   [2];
    logic  qry_ready [2];
    logic  qry_chk   [2];
    logic  qry_exp   [2];
    logic  cdb_valid [CDB_COUNT];
    tag_t  cdb_tag   [CDB_COUNT];
    data_t cdb_data  [CDB_COUNT];
    logic  cdb_wreg  [CDB_COUNT];
    int    value_errs;
    int    other_errs;

    string lines [$];
    int    n_lines = 0;
    int    bad_lines = 0;
    string tok [32];
    int    ntok;

    cdb_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) uut (
        .clk(clk), .arst_n_i(arst_n), .flush_i(flush),
        .res_valid_i(res_valid), .res_tag_i(res_tag), .res_data_i(res_data),
        .res_wreg_i(res_wreg), .res_ready_o(res_ready),
        .alloc_valid_i(alloc_valid), .alloc_tag_i(alloc_tag),
        .qry_tag_i(qry_tag), .qry_ready_o(qry_ready),
        .cdb_valid_o(cdb_valid), .cdb_tag_o(cdb_tag), .cdb_data_o(cdb_data),
        .cdb_wreg_o(cdb_wreg)
    );

    cdb_monitor #(.QUEUE_DEPTH(QUEUE_DEPTH)) chk (
        .clk(clk), .arst_n_i(arst_n), .flush_i(flush),
        .res_valid_i(res_valid), .res_tag_i(res_tag), .res_data_i(res_data),
        .res_wreg_i(res_wreg), .res_ready_i(res_ready),
        .alloc_valid_i(alloc_valid), .alloc_tag_i(alloc_tag),
        .qry_tag_i(qry_tag), .qry_ready_i(qry_ready), .qry_chk_i(qry_chk), .qry_exp_i(qry_exp),
        .cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag), .cdb_data_i(cdb_data),
        .cdb_wreg_i(cdb_wreg),
        .value_errs_o(value_errs), .other_errs_o(other_errs)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic tokenize(input string line);
        string cur;
        byte   c;
        ntok = 0;
        cur  = "";
        for (int i = 0; i < line.len(); i++) begin
            c = line[i];
            if (c == " " || c == "\t" || c == "\n" || c == "\r") begin
                if (cur.len() > 0 && ntok < 32) begin
                    tok[ntok] = cur;
                    ntok++;
                end
                cur = "";
            end else begin
                cur = $sformatf("%s%c", cur, c);
            end
        end
        if (cur.len() > 0 && ntok < 32) begin
            tok[ntok] = cur;
            ntok++;
        end
    endtask

    // one cycle, a result not yet taken stays on the unit's port
    task automatic drive_cycle(input bit use_line);
        logic acc [UNIT_COUNT];
        @(negedge clk);
        for (int u = 0; u < UNIT_COUNT; u++) begin
            acc[u] = res_valid[u] && res_ready[u];
        end
        @(posedge clk);
        #1;
        for (int u = 0; u < UNIT_COUNT; u++) begin
            if (res_valid[u] && !acc[u]) begin
                res_valid[u] = 1'b1; // held
            end else if (use_line) begin
                res_valid[u] = tok[4*u] == "1";
                res_tag[u]   = tag_t'(tok[4*u+1].atohex());
                res_data[u]  = (tok[4*u+2] == "r") ? $urandom : data_t'(tok[4*u+2].atohex());
                res_wreg[u]  = tok[4*u+3] == "1";
            end else begin
                res_valid[u] = 1'b0;
            end
        end
        alloc_valid = use_line && tok[16] == "1";
        alloc_tag   = use_line ? tag_t'(tok[17].atohex()) : '0;
        flush       = use_line && tok[18] == "1";
        for (int q = 0; q < 2; q++) begin
            qry_tag[q] = use_line ? tag_t'(tok[19+2*q].atohex()) : '0;
            qry_chk[q] = use_line && tok[20+2*q] != "-";
            qry_exp[q] = use_line && tok[20+2*q] == "1";
        end
    endtask

    initial begin
        wait (n_lines > 0);
        #((n_lines + 50) * CLK_PERIOD);
        $display("timeout: run did not finish in time");
        $display("errors: %0d value, %0d other", value_errs, other_errs + bad_lines);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int    fd;
        string line;
        clk = 1'b0;
        arst_n = 1'b0;
        flush = 1'b0;
        alloc_valid = 1'b0;
        alloc_tag = '0;
        for (int u = 0; u < UNIT_COUNT; u++) begin
            res_valid[u] = 1'b0;
            res_tag[u]   = '0;
            res_data[u]  = '0;
            res_wreg[u]  = 1'b0;
        end
        for (int q = 0; q < 2; q++) begin
            qry_tag[q] = '0;
            qry_chk[q] = 1'b0;
            qry_exp[q] = 1'b0;
        end
        void'($urandom(SEED));
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open pattern file %s", PATTERN_FILE);
            bad_lines++;
        end else begin
            while ($fgets(line, fd)) begin
                tokenize(line);
                if (ntok > 0 && tok[0][0] != "#") lines.push_back(line);
            end
            $fclose(fd);
        end
        n_lines = lines.size();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
        foreach (lines[i]) begin
            tokenize(lines[i]);
            if (ntok != NUM_FIELDS) begin
                $display("pattern line %0d has %0d fields instead of %0d", i, ntok, NUM_FIELDS);
                bad_lines++;
                drive_cycle(1'b0);
            end else begin
                drive_cycle(1'b1);
            end
        end
        repeat (DRAIN_CYCLES) drive_cycle(1'b0);
        @(negedge clk);
        #1; // after the monitor's own falling edge step
        chk.check_drained();
        #1;
        $display("errors: %0d value, %0d other", value_errs, other_errs + bad_lines);
        if (value_errs == 0 && other_errs == 0 && bad_lines == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/cdb_monitor.sv */
`default_nettype none

// watches the dut ports, models queues, arbiter and scoreboard, counts mismatches
module cdb_monitor import cdb_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  flush_i,
    input  logic  res_valid_i [UNIT_COUNT],
    input  tag_t  res_tag_i   [UNIT_COUNT],
    input  data_t res_data_i  [UNIT_COUNT],
    input  logic  res_wreg_i  [UNIT_COUNT],
    input  logic  res_ready_i [UNIT_COUNT],
    input  logic  alloc_valid_i,
    input  tag_t  alloc_tag_i,
    input  tag_t  qry_tag_i   [2],
    input  logic  qry_ready_i [2],
    input  logic  qry_chk_i   [2], // pattern file gives an answer
    input  logic  qry_exp_i   [2],
    input  logic  cdb_valid_i [CDB_COUNT],
    input  tag_t  cdb_tag_i   [CDB_COUNT],
    input  data_t cdb_data_i  [CDB_COUNT],
    input  logic  cdb_wreg_i  [CDB_COUNT],
    output int    value_errs_o,
    output int    other_errs_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ENT_W = 1 + TAG_W + DATA_W; // {wreg, tag, data}

    logic [ENT_W-1:0]      pend [UNIT_COUNT][QUEUE_DEPTH];
    int                    cnt  [UNIT_COUNT];
    int                    ptr;
    logic                  exp_v [CDB_COUNT]; // slots expected on the bus this cycle
    logic [ENT_W-1:0]      exp_e [CDB_COUNT];
    logic [(1<<TAG_W)-1:0] sb;

    initial begin
        value_errs_o = 0;
        other_errs_o = 0;
    end

    task automatic value_err(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("ERR %s got %0h exp %0h", name, got, exp);
        value_errs_o++;
    endtask

    task automatic reset_model();
        for (int u = 0; u < UNIT_COUNT; u++) begin
            cnt[u] = 0;
        end
        for (int s = 0; s < CDB_COUNT; s++) begin
            exp_v[s] = 1'b0;
        end
        ptr = 0;
        sb  = '1;
    endtask

    task automatic check_bus();
        for (int s = 0; s < CDB_COUNT; s++) begin
            if (cdb_valid_i[s] !== exp_v[s]) begin
                value_err($sformatf("cdb_valid_o[%0d]", s), 64'(cdb_valid_i[s]), 64'(exp_v[s]));
            end else if (exp_v[s]) begin
                if (cdb_tag_i[s] !== exp_e[s][DATA_W +: TAG_W])
                    value_err($sformatf("cdb_tag_o[%0d]", s), 64'(cdb_tag_i[s]),
                              64'(exp_e[s][DATA_W +: TAG_W]));
                if (cdb_data_i[s] !== exp_e[s][DATA_W-1:0])
                    value_err($sformatf("cdb_data_o[%0d]", s), 64'(cdb_data_i[s]),
                              64'(exp_e[s][DATA_W-1:0]));
                if (cdb_wreg_i[s] !== exp_e[s][ENT_W-1])
                    value_err($sformatf("cdb_wreg_o[%0d]", s), 64'(cdb_wreg_i[s]),
                              64'(exp_e[s][ENT_W-1]));
            end
        end
    endtask

    task automatic check_queries();
        logic e;
        for (int q = 0; q < 2; q++) begin
            e = sb[qry_tag_i[q]];
            for (int s = 0; s < CDB_COUNT; s++) begin
                if (exp_v[s] && exp_e[s][ENT_W-1] && exp_e[s][DATA_W +: TAG_W] == qry_tag_i[q])
                    e = 1'b1; // same cycle forward
            end
            if (qry_ready_i[q] !== e)
                value_err($sformatf("qry_ready_o[%0d]", q), 64'(qry_ready_i[q]), 64'(e));
            if (qry_chk_i[q] && qry_ready_i[q] !== qry_exp_i[q])
                value_err($sformatf("qry_ready_o[%0d] vs pattern", q), 64'(qry_ready_i[q]),
                          64'(qry_exp_i[q]));
        end
    endtask

    task automatic check_ready();
        logic e;
        for (int u = 0; u < UNIT_COUNT; u++) begin
            e = (cnt[u] < QUEUE_DEPTH);
            if (res_ready_i[u] !== e)
                value_err($sformatf("res_ready_o[%0d]", u), 64'(res_ready_i[u]), 64'(e));
        end
    endtask

    task automatic pop_front(input int u);
        for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
            pend[u][i] = pend[u][i+1];
        end
        cnt[u]--;
    endtask

    // state update for the coming edge
    task automatic advance();
        int gidx [CDB_COUNT];
        int nfound;
        int u;
        nfound = 0;
        for (int k = 0; k < UNIT_COUNT; k++) begin
            u = (ptr + k) % UNIT_COUNT;
            if (cnt[u] > 0 && nfound < CDB_COUNT) begin
                gidx[nfound] = u;
                nfound++;
            end
        end
        if (flush_i) begin
            sb = '1;
        end else begin
            for (int s = 0; s < CDB_COUNT; s++) begin
                if (exp_v[s] && exp_e[s][ENT_W-1]) sb[exp_e[s][DATA_W +: TAG_W]] = 1'b1;
            end
            if (alloc_valid_i) sb[alloc_tag_i] = 1'b0; // alloc wins the tie
        end
        if (flush_i) begin
            reset_model();
        end else begin
            for (int s = 0; s < CDB_COUNT; s++) begin
                exp_v[s] = (s < nfound);
                if (s < nfound) exp_e[s] = pend[gidx[s]][0];
            end
            for (int i = 0; i < nfound; i++) begin
                pop_front(gidx[i]);
            end
            if (nfound > 0) ptr = (gidx[nfound-1] + 1) % UNIT_COUNT;
            for (int v = 0; v < UNIT_COUNT; v++) begin
                if (res_valid_i[v] && res_ready_i[v]) begin
                    if (cnt[v] < QUEUE_DEPTH) begin
                        pend[v][cnt[v]] = {res_wreg_i[v], res_tag_i[v], res_data_i[v]};
                        cnt[v]++;
                    end else begin
                        $display("unit %0d accepted a result while its queue was full", v);
                        other_errs_o++;
                    end
                end
            end
        end
    endtask

    task automatic check_drained();
        for (int u = 0; u < UNIT_COUNT; u++) begin
            if (cnt[u] != 0) begin
                $display("unit %0d has %0d accepted results that never reached the bus",
                         u, cnt[u]);
                other_errs_o++;
            end
        end
        for (int s = 0; s < CDB_COUNT; s++) begin
            if (exp_v[s]) begin
                $display("cdb slot %0d still has a result to deliver at the end of the run", s);
                other_errs_o++;
            end
        end
    endtask

    // inputs settle 1 ns after the rising edge, so the falling edge is a quiet point
    always @(negedge clk) begin
        if (!arst_n_i) begin
            reset_model();
            check_ready();
            check_bus();
        end else begin
            check_bus();
            check_queries();
            check_ready();
            advance();
        end
    end

endmodule

`default_nettype wire

/* logic/cdb_top.sv */
`default_nettype none

// result writeback path: four unit queues, cdb arbiter, tag scoreboard
module cdb_top import cdb_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  flush_i,

    // per unit results, unit 0/1 alu, 2 lsu, 3 mdu
    input  logic  res_valid_i [UNIT_COUNT],
    input  tag_t  res_tag_i   [UNIT_COUNT],
    input  data_t res_data_i  [UNIT_COUNT],
    input  logic  res_wreg_i  [UNIT_COUNT],
    output logic  res_ready_o [UNIT_COUNT],

    input  logic  alloc_valid_i,
    input  tag_t  alloc_tag_i,

    input  tag_t  qry_tag_i   [2],
    output logic  qry_ready_o [2],

    output logic  cdb_valid_o [CDB_COUNT],
    output tag_t  cdb_tag_o   [CDB_COUNT],
    output data_t cdb_data_o  [CDB_COUNT],
    output logic  cdb_wreg_o  [CDB_COUNT]
);

    // queue heads toward the arbiter
    logic  head_valid [UNIT_COUNT];
    tag_t  head_tag   [UNIT_COUNT];
    data_t head_data  [UNIT_COUNT];
    logic  head_wreg  [UNIT_COUNT];
    logic  head_pop   [UNIT_COUNT];

    for (genvar u = 0; u < UNIT_COUNT; u++) begin : g_queue
        result_queue #(
            .QUEUE_DEPTH(QUEUE_DEPTH)
        ) u_result_queue (
            .clk(clk),
            .arst_n_i(arst_n_i),
            .flush_i(flush_i),

            .push_valid_i(res_valid_i[u]),
            .push_tag_i(res_tag_i[u]),
            .push_data_i(res_data_i[u]),
            .push_wreg_i(res_wreg_i[u]),
            .push_ready_o(res_ready_o[u]),

            .pop_i(head_pop[u]),
            .head_valid_o(head_valid[u]),
            .head_tag_o(head_tag[u]),
            .head_data_o(head_data[u]),
            .head_wreg_o(head_wreg[u])
        );
    end

    cdb_arbiter u_cdb_arbiter (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .flush_i(flush_i),

        .head_valid_i(head_valid),
        .head_tag_i(head_tag),
        .head_data_i(head_data),
        .head_wreg_i(head_wreg),
        .pop_o(head_pop),

        .cdb_valid_o(cdb_valid_o),
        .cdb_tag_o(cdb_tag_o),
        .cdb_data_o(cdb_data_o),
        .cdb_wreg_o(cdb_wreg_o)
    );

    // scoreboard listens to the registered bus slots
    tag_scoreboard u_tag_scoreboard (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .flush_i(flush_i),

        .alloc_valid_i(alloc_valid_i),
        .alloc_tag_i(alloc_tag_i),

        .cdb_valid_i(cdb_valid_o),
        .cdb_tag_i(cdb_tag_o),
        .cdb_wreg_i(cdb_wreg_o),

        .qry_tag_i(qry_tag_i),
        .qry_ready_o(qry_ready_o)
    );

endmodule

`default_nettype wire

/* logic/tag_scoreboard.sv */
`default_nettype none

// one ready bit per physical tag
// alloc clears, a writing broadcast sets, alloc wins on the same tag
module tag_scoreboard import cdb_pkg::*; (
    input  logic clk,
    input  logic arst_n_i,
    input  logic flush_i,

    input  logic alloc_valid_i,
    input  tag_t alloc_tag_i,

    input  logic cdb_valid_i [CDB_COUNT],
    input  tag_t cdb_tag_i   [CDB_COUNT],
    input  logic cdb_wreg_i  [CDB_COUNT],

    input  tag_t qry_tag_i   [2],
    output logic qry_ready_o [2]
);

    localparam int TAG_COUNT = 1 << TAG_W;
    localparam int QRY_COUNT = 2;

    logic [TAG_COUNT-1:0] ready_q;
    logic                 cdb_write [CDB_COUNT];

    always_comb begin
        for (int s = 0; s < CDB_COUNT; s++) begin
            cdb_write[s] = cdb_valid_i[s] && cdb_wreg_i[s]; // only register writes wake
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_q <= '1;
        end else if (flush_i) begin
            ready_q <= '1; // nothing is pending after a flush
        end else begin
            for (int s = 0; s < CDB_COUNT; s++) begin
                if (cdb_write[s]) begin
                    ready_q[cdb_tag_i[s]] <= 1'b1;
                end
            end
            // last assignment wins, so alloc beats a broadcast of the same tag
            if (alloc_valid_i) begin
                ready_q[alloc_tag_i] <= 1'b0;
            end
        end
    end

    // stored bit plus same cycle forward from the bus
    always_comb begin
        for (int q = 0; q < QRY_COUNT; q++) begin
            qry_ready_o[q] = ready_q[qry_tag_i[q]];
            for (int s = 0; s < CDB_COUNT; s++) begin
                if (cdb_write[s] && (cdb_tag_i[s] == qry_tag_i[q])) begin
                    qry_ready_o[q] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/cdb_arbiter.sv */
`default_nettype none

// two slot cdb arbiter with rotating priority
// slot 0 gets the first ready head at or after the pointer, slot 1 the next one
module cdb_arbiter import cdb_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  flush_i,

    input  logic  head_valid_i [UNIT_COUNT],
    input  tag_t  head_tag_i   [UNIT_COUNT],
    input  data_t head_data_i  [UNIT_COUNT],
    input  logic  head_wreg_i  [UNIT_COUNT],
    output logic  pop_o        [UNIT_COUNT],

    output logic  cdb_valid_o  [CDB_COUNT],
    output tag_t  cdb_tag_o    [CDB_COUNT],
    output data_t cdb_data_o   [CDB_COUNT],
    output logic  cdb_wreg_o   [CDB_COUNT]
);

    unit_idx_t ptr_q;   // highest priority unit
    unit_idx_t ptr_d;
    unit_idx_t scan_idx;

    unit_idx_t sel_idx   [CDB_COUNT];
    logic      sel_found [CDB_COUNT];

    // walk the units starting at the pointer, take the first two non-empty
    always_comb begin
        sel_found[0] = 1'b0;
        sel_found[1] = 1'b0;
        sel_idx[0]   = ptr_q;
        sel_idx[1]   = ptr_q;
        scan_idx     = ptr_q;
        for (int k = 0; k < UNIT_COUNT; k++) begin
            scan_idx = ptr_q + unit_idx_t'(k); // wraps at UNIT_COUNT
            if (head_valid_i[scan_idx]) begin
                if (!sel_found[0]) begin
                    sel_found[0] = 1'b1;
                    sel_idx[0]   = scan_idx;
                end else if (!sel_found[1]) begin
                    sel_found[1] = 1'b1;
                    sel_idx[1]   = scan_idx;
                end
            end
        end
    end

    // one pop per granted queue, the two slots never pick the same unit
    always_comb begin
        for (int u = 0; u < UNIT_COUNT; u++) begin
            pop_o[u] = (sel_found[0] && (sel_idx[0] == unit_idx_t'(u)))
                    || (sel_found[1] && (sel_idx[1] == unit_idx_t'(u)));
        end
    end

    // pointer moves past the last granted unit
    always_comb begin
        ptr_d = ptr_q;
        if (sel_found[1]) begin
            ptr_d = sel_idx[1] + unit_idx_t'(1);
        end else if (sel_found[0]) begin
            ptr_d = sel_idx[0] + unit_idx_t'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
            for (int s = 0; s < CDB_COUNT; s++) begin
                cdb_valid_o[s] <= 1'b0;
            end
        end else if (flush_i) begin
            ptr_q <= '0;
            for (int s = 0; s < CDB_COUNT; s++) begin
                cdb_valid_o[s] <= 1'b0; // bus is quiet the cycle after a flush
            end
        end else begin
            ptr_q <= ptr_d;
            for (int s = 0; s < CDB_COUNT; s++) begin
                cdb_valid_o[s] <= sel_found[s];
            end
        end
    end

    // slot payload, only meaningful with cdb_valid_o
    always_ff @(posedge clk) begin
        for (int s = 0; s < CDB_COUNT; s++) begin
            if (sel_found[s]) begin
                cdb_tag_o[s]  <= head_tag_i[sel_idx[s]];
                cdb_data_o[s] <= head_data_i[sel_idx[s]];
                cdb_wreg_o[s] <= head_wreg_i[sel_idx[s]];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/result_queue.sv */
`default_nettype none

// per unit result fifo, no bypass, doubles as the pipeline register
// between an execution unit and the cdb
module result_queue import cdb_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  flush_i,

    input  logic  push_valid_i,
    input  tag_t  push_tag_i,
    input  data_t push_data_i,
    input  logic  push_wreg_i,
    output logic  push_ready_o,

    input  logic  pop_i,
    output logic  head_valid_o,
    output tag_t  head_tag_o,
    output data_t head_data_o,
    output logic  head_wreg_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    tag_t  tag_mem  [QUEUE_DEPTH];
    data_t data_mem [QUEUE_DEPTH];
    logic  wreg_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic push_fire;
    logic pop_fire;

    assign push_ready_o = (count_q != CNT_W'(QUEUE_DEPTH)); // not full
    assign head_valid_o = (count_q != '0);
    assign push_fire    = push_valid_i && push_ready_o;
    assign pop_fire     = pop_i && head_valid_o;

    // oldest entry
    assign head_tag_o  = tag_mem[rd_ptr_q];
    assign head_data_o = data_mem[rd_ptr_q];
    assign head_wreg_o = wreg_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push_fire) begin
            tag_mem[wr_ptr_q]  <= push_tag_i;
            data_mem[wr_ptr_q] <= push_data_i;
            wreg_mem[wr_ptr_q] <= push_wreg_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0; // drop everything in flight
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1); // wraps, depth is a power of two
            end
            if (pop_fire) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
            if (push_fire && !pop_fire) begin
                count_q <= count_q + CNT_W'(1);
            end else if (pop_fire && !push_fire) begin
                count_q <= count_q - CNT_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/cdb_pkg.sv */
`default_nettype none

// shared widths and types for the result writeback path
package cdb_pkg;

    // result value width
    localparam int DATA_W = 32;

    // physical register tag, 64 tags
    localparam int TAG_W = 6;

    localparam int UNIT_COUNT = 4; // alu0, alu1, lsu, mdu

    // bus slots per cycle, the arbiter is built around two
    localparam int CDB_COUNT = 2;

    typedef logic [DATA_W-1:0] data_t;

    typedef logic [TAG_W-1:0] tag_t;

    // source unit index, also the rotating pointer
    typedef logic [1:0] unit_idx_t;

endpackage

`default_nettype wire
